// ==== source/dma_pkg.sv ====
package dma_pkg;

    // Sizing
    localparam int buffer_depth = 256;
    localparam int memory_depth = 256;

    typedef logic [7:0] buffer_address_t;

    // Word address on the bus, byte offset is always zero
    typedef struct packed {
        logic [29:0] word_index;
        logic [1:0]  byte_offset;
    } bus_address_t;

    // Address in the begin cycle, data in every other cycle
    typedef union packed {
        bus_address_t address;
        logic [31:0]  data;
    } bus_word_u;

    typedef struct packed {
        logic         read_n_write;
        bus_address_t start;
        logic [7:0]   burst_length;
        logic [8:0]   block_length;
    } dma_command_t;

    typedef struct packed {
        logic       begin_transaction;
        logic       read_n_write;
        logic [7:0] burst_length;
        logic       end_transaction;
        logic       data_valid;
        bus_word_u  word;
    } bus_master_t;

    typedef struct packed {
        logic        data_valid;
        logic        end_transaction;
        logic        bus_error;
        logic [31:0] data;
    } bus_target_t;

    typedef struct packed {
        logic done;
        logic error;
    } dma_status_t;

endpackage

// ==== source/dma_controller.sv ====
`timescale 1ns/1ps

module dma_controller (
    input  logic                     clock,
    input  logic                     n_reset,
    input  logic                     launch,
    input  dma_pkg::dma_command_t    command,
    output logic                     busy,
    output dma_pkg::dma_status_t     status,
    output logic                     request,
    input  logic                     grant,
    output dma_pkg::bus_master_t     master,
    input  dma_pkg::bus_target_t     target,
    output dma_pkg::buffer_address_t buffer_address,
    output logic                     buffer_write,
    output logic [31:0]              buffer_write_data,
    input  logic [31:0]              buffer_read_data
);
    import dma_pkg::*;

    typedef enum logic [2:0] {
        state_idle,
        state_request,
        state_set_up,
        state_read,
        state_write,
        state_end_burst
    } state_t;

    state_t          state;
    state_t          next_state;
    logic            read_n_write;
    logic            error_flag;
    logic            end_error;
    logic            word_step;
    logic            last_burst_word;
    logic [7:0]      burst_length;
    logic [7:0]      burst_left;
    logic [7:0]      trimmed_length;
    logic [8:0]      remaining;
    logic [8:0]      burst_words;
    bus_address_t    bus_address;
    buffer_address_t buffer_index;

    // Last burst of a block may be shorter than the programmed length
    assign burst_words = ({1'b0, burst_length} + 9'd1 < remaining) ?
                         {1'b0, burst_length} + 9'd1 : remaining;
    assign trimmed_length = 8'(burst_words - 9'd1);

    assign word_step = (state == state_write) || (state == state_read && target.data_valid);
    assign last_burst_word = (burst_left == 8'd0);

    // A one-word write burst is already over when its error comes back
    assign end_error = (state == state_end_burst) && target.bus_error;

    always_comb begin
        next_state = state;
        case (state)
            state_idle:      if (launch) next_state = state_request;
            state_request:   if (grant) next_state = state_set_up;
            state_set_up:    next_state = read_n_write ? state_read : state_write;
            // An error burst also ends with end_transaction
            state_read:      if (target.end_transaction) next_state = state_end_burst;
            state_write:     if (last_burst_word || target.bus_error) next_state = state_end_burst;
            state_end_burst: begin
                if (error_flag || end_error || remaining == 9'd0) begin
                    next_state = state_idle;
                end else begin
                    next_state = state_request;
                end
            end
            default:         next_state = state_idle;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!n_reset) begin
            state <= state_idle;
            error_flag <= 1'b0;
        end else begin
            state <= next_state;
            if (state == state_idle && launch) begin
                error_flag <= 1'b0;
            end else if (target.bus_error &&
                         state inside {state_read, state_write, state_end_burst}) begin
                error_flag <= 1'b1;
            end
        end
    end

    // Command latch and running counters
    always_ff @(posedge clock) begin
        if (state == state_idle && launch) begin
            read_n_write <= command.read_n_write;
            burst_length <= command.burst_length;
            bus_address <= command.start;
            remaining <= command.block_length;
            buffer_index <= '0;
        end else if (state == state_set_up) begin
            burst_left <= trimmed_length;
        end else if (word_step) begin
            bus_address.word_index <= bus_address.word_index + 30'd1;
            remaining <= remaining - 9'd1;
            buffer_index <= buffer_index + 8'd1;
            burst_left <= burst_left - 8'd1;
        end
    end

    assign busy = (state != state_idle);
    assign request = state inside {state_request, state_set_up, state_read, state_write};
    assign status.done = (state == state_end_burst) && (next_state == state_idle);
    assign status.error = error_flag || end_error;

    always_comb begin
        master = '0;
        if (state == state_set_up) begin
            master.begin_transaction = 1'b1;
            master.read_n_write = read_n_write;
            master.burst_length = trimmed_length;
            master.word.address = bus_address;
        end else if (state == state_write) begin
            master.data_valid = 1'b1;
            master.end_transaction = last_burst_word;
            master.word.data = buffer_read_data;
        end
    end

    // Fetch one word ahead while writing to the bus
    assign buffer_address = (state == state_write) ? buffer_index + 8'd1 : buffer_index;
    assign buffer_write = (state == state_read) && target.data_valid;
    assign buffer_write_data = target.data;

    begin_needs_grant: assert property (
        @(posedge clock) disable iff (!n_reset)
        master.begin_transaction |-> grant
    ) else $error("begin_transaction without grant");

    buffer_write_in_read: assert property (
        @(posedge clock) disable iff (!n_reset)
        buffer_write |-> read_n_write && grant
    ) else $error("buffer write outside a granted read burst");

endmodule

// ==== source/dma_buffer.sv ====
`timescale 1ns/1ps

module dma_buffer (
    input  logic                     clock,
    input  logic                     n_reset,
    input  dma_pkg::buffer_address_t dma_address,
    input  logic                     dma_write,
    input  logic [31:0]              dma_write_data,
    output logic [31:0]              dma_read_data,
    input  dma_pkg::buffer_address_t host_address,
    input  logic                     host_write,
    input  logic [31:0]              host_write_data,
    output logic [31:0]              host_read_data
);
    import dma_pkg::*;

    logic [31:0] words [buffer_depth];

    // DMA write comes last so it wins on a shared word
    always_ff @(posedge clock) begin
        if (host_write) words[host_address] <= host_write_data;
        if (dma_write) words[dma_address] <= dma_write_data;
    end

    always_ff @(posedge clock) begin
        if (!n_reset) begin
            dma_read_data <= '0;
            host_read_data <= '0;
        end else begin
            dma_read_data <= words[dma_address];
            host_read_data <= words[host_address];
        end
    end

endmodule

// ==== source/bus_arbiter.sv ====
`timescale 1ns/1ps

module bus_arbiter (
    input  logic clock,
    input  logic n_reset,
    input  logic dma_request,
    input  logic ext_request,
    output logic dma_grant,
    output logic ext_grant
);

    // High when the external requester had the bus last
    logic ext_served_last;

    always_ff @(posedge clock) begin
        if (!n_reset) begin
            dma_grant <= 1'b0;
            ext_grant <= 1'b0;
            ext_served_last <= 1'b0;
        end else if (dma_grant) begin
            if (!dma_request) dma_grant <= 1'b0;
        end else if (ext_grant) begin
            if (!ext_request) ext_grant <= 1'b0;
        end else if (dma_request && (!ext_request || ext_served_last)) begin
            dma_grant <= 1'b1;
            ext_served_last <= 1'b0;
        end else if (ext_request) begin
            ext_grant <= 1'b1;
            ext_served_last <= 1'b1;
        end
    end

    one_owner: assert property (@(posedge clock) disable iff (!n_reset) !(dma_grant && ext_grant))
        else $error("both masters granted");

endmodule

// ==== source/bus_memory.sv ====
`timescale 1ns/1ps

module bus_memory (
    input  logic                 clock,
    input  logic                 n_reset,
    input  dma_pkg::bus_master_t master,
    output dma_pkg::bus_target_t target
);
    import dma_pkg::*;

    logic [31:0] words [memory_depth];
    logic [$clog2(memory_depth)-1:0] read_address;
    logic [$clog2(memory_depth)-1:0] write_address;
    logic [7:0] read_left;
    logic [30:0] last_word;
    bus_address_t begin_address;
    logic read_active;
    logic write_active;
    logic error_pending;
    logic read_valid;
    logic read_end;
    logic error_strobe;
    logic [31:0] read_data;

    // Begin word seen through its address view
    assign begin_address = master.word.address;
    assign last_word = {1'b0, begin_address.word_index} + 31'(master.burst_length);

    always_ff @(posedge clock) begin
        if (!n_reset) begin
            read_active <= 1'b0;
            write_active <= 1'b0;
            error_pending <= 1'b0;
            read_valid <= 1'b0;
            read_end <= 1'b0;
            error_strobe <= 1'b0;
        end else begin
            read_valid <= read_active;
            read_end <= read_active && (read_left == 8'd0);
            error_strobe <= error_pending;
            error_pending <= 1'b0;
            if (read_active) begin
                read_address <= read_address + 1'b1;
                read_left <= read_left - 8'd1;
                if (read_left == 8'd0) read_active <= 1'b0;
            end
            if (write_active && master.data_valid) begin
                write_address <= write_address + 1'b1;
                if (master.end_transaction) write_active <= 1'b0;
            end
            if (master.begin_transaction) begin
                if (last_word >= 31'(memory_depth)) begin
                    error_pending <= 1'b1;
                end else if (master.read_n_write) begin
                    read_active <= 1'b1;
                    read_address <= begin_address.word_index[$clog2(memory_depth)-1:0];
                    read_left <= master.burst_length;
                end else begin
                    write_active <= 1'b1;
                    write_address <= begin_address.word_index[$clog2(memory_depth)-1:0];
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (write_active && master.data_valid) words[write_address] <= master.word.data;
        read_data <= words[read_address];
    end

    // First read word lands two cycles after begin
    assign target.data_valid = read_valid;
    assign target.end_transaction = read_end || error_strobe;
    assign target.bus_error = error_strobe;
    assign target.data = read_data;

    quiet_master_on_read: assert property (
        @(posedge clock) disable iff (!n_reset)
        (read_active || read_valid) |-> !master.data_valid
    ) else $error("master data_valid during a read burst");

endmodule

// ==== source/dma_subsystem.sv ====
`timescale 1ns/1ps

module dma_subsystem (
    input  logic                     clock,
    input  logic                     n_reset,
    input  logic                     launch,
    input  dma_pkg::dma_command_t    command,
    output logic                     busy,
    output dma_pkg::dma_status_t     status,
    input  logic                     ext_request,
    output logic                     ext_grant,
    input  dma_pkg::bus_master_t     ext_master,
    input  dma_pkg::buffer_address_t host_address,
    input  logic                     host_write,
    input  logic [31:0]              host_write_data,
    output logic [31:0]              host_read_data
);
    import dma_pkg::*;

    bus_master_t     dma_master;
    bus_master_t     bus_master;
    bus_target_t     bus_target;
    logic            dma_request;
    logic            dma_grant;
    buffer_address_t buffer_address;
    logic            buffer_write;
    logic [31:0]     buffer_write_data;
    logic [31:0]     buffer_read_data;

    // Granted master drives the bus, idle bus is all zero
    always_comb begin
        if (dma_grant) begin
            bus_master = dma_master;
        end else if (ext_grant) begin
            bus_master = ext_master;
        end else begin
            bus_master = '0;
        end
    end

    dma_controller controller_inst (
        .clock(clock), .n_reset(n_reset), .launch(launch), .command(command),
        .busy(busy), .status(status), .request(dma_request), .grant(dma_grant),
        .master(dma_master), .target(bus_target), .buffer_address(buffer_address),
        .buffer_write(buffer_write), .buffer_write_data(buffer_write_data),
        .buffer_read_data(buffer_read_data));

    dma_buffer buffer_inst (
        .clock(clock), .n_reset(n_reset), .dma_address(buffer_address),
        .dma_write(buffer_write), .dma_write_data(buffer_write_data),
        .dma_read_data(buffer_read_data), .host_address(host_address),
        .host_write(host_write), .host_write_data(host_write_data),
        .host_read_data(host_read_data));

    bus_arbiter arbiter_inst (
        .clock(clock), .n_reset(n_reset), .dma_request(dma_request),
        .ext_request(ext_request), .dma_grant(dma_grant), .ext_grant(ext_grant));

    bus_memory memory_inst (
        .clock(clock), .n_reset(n_reset), .master(bus_master), .target(bus_target));

endmodule

// ==== tests/dma_subsystem_tb.sv ====
`timescale 1ns/1ps

module dma_subsystem_tb;
    import dma_pkg::*;

    localparam int row_count = 10;
    localparam int cycles_per_row = 400;
    localparam int cycles_per_word = 2;

    // One DMA run per row
    typedef struct packed {
        logic       read_n_write;
        logic [7:0] start;
        logic [7:0] burst_length;
        logic [8:0] block_length;
        logic [7:0] ext_hold;
        logic       expect_error;
    } row_t;

    logic            clock;
    logic            n_reset;
    logic            launch;
    dma_command_t    command;
    logic            busy;
    dma_status_t     status;
    logic            ext_request;
    logic            ext_grant;
    bus_master_t     ext_master;
    buffer_address_t host_address;
    logic            host_write;
    logic [31:0]     host_write_data;
    logic [31:0]     host_read_data;

    // Expected buffer contents and a model of the bus memory
    logic [31:0] image [buffer_depth];
    logic [31:0] model [memory_depth];
    int          seed;
    int          error_count;
    int          cycle_count;
    int          timeout_limit;

    dma_subsystem dma_subsystem_inst (
        .clock(clock),
        .n_reset(n_reset),
        .launch(launch),
        .command(command),
        .busy(busy),
        .status(status),
        .ext_request(ext_request),
        .ext_grant(ext_grant),
        .ext_master(ext_master),
        .host_address(host_address),
        .host_write(host_write),
        .host_write_data(host_write_data),
        .host_read_data(host_read_data)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (timeout_limit != 0 && cycle_count >= timeout_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", timeout_limit);
            $display("Verification failed");
            $finish;
        end
    end

    function automatic void log_error(input string message);
        error_count++;
        $display("[ERROR] %0t ns: %s", $time, message);
    endfunction

    // Each row holds direction, start word, burst length minus one, block length,
    // ext hold and expected error
    function automatic row_t row_at(input int index);
        row_t row;
        case (index)
            0: row = '{1'b0, 8'd0, 8'd63, 9'd32, 8'd0, 1'b0};
            1: row = '{1'b1, 8'd0, 8'd63, 9'd32, 8'd0, 1'b0};
            2: row = '{1'b0, 8'd40, 8'd7, 9'd37, 8'd0, 1'b0};
            3: row = '{1'b1, 8'd40, 8'd7, 9'd37, 8'd0, 1'b0};
            4: row = '{1'b0, 8'd100, 8'd0, 9'd12, 8'd0, 1'b0};
            5: row = '{1'b1, 8'd100, 8'd0, 9'd12, 8'd0, 1'b0};
            6: row = '{1'b0, 8'd120, 8'd15, 9'd64, 8'd25, 1'b0};
            7: row = '{1'b1, 8'd120, 8'd15, 9'd64, 8'd15, 1'b0};
            // Both cross the end of memory in their fifth burst
            8: row = '{1'b0, 8'd192, 8'd15, 9'd80, 8'd0, 1'b1};
            9: row = '{1'b1, 8'd224, 8'd7, 9'd40, 8'd0, 1'b1};
            default: row = '0;
        endcase
        return row;
    endfunction

    // Words moved before the first burst that would leave the memory
    function automatic int completed_words(input row_t row);
        int size;
        int moved;
        int chunk;
        logic stopped;
        size = int'(row.burst_length) + 1;
        moved = 0;
        stopped = 1'b0;
        while (!stopped && moved < int'(row.block_length)) begin
            chunk = int'(row.block_length) - moved;
            if (chunk > size) chunk = size;
            if (int'(row.start) + moved + chunk - 1 >= memory_depth) begin
                stopped = 1'b1;
            end else begin
                moved += chunk;
            end
        end
        return moved;
    endfunction

    task automatic load_image(input int count);
        for (int i = 0; i < count; i++) begin
            @(negedge clock);
            host_address = 8'(i);
            host_write = 1'b1;
            host_write_data = image[i];
        end
        @(negedge clock);
        host_write = 1'b0;
    endtask

    task automatic check_image(input int count);
        for (int i = 0; i < count; i++) begin
            @(negedge clock);
            host_address = 8'(i);
            @(negedge clock);
            assert (host_read_data === image[i]) else
                log_error($sformatf("buffer word %0d is %h, expected %h",
                                    i, host_read_data, image[i]));
        end
    endtask

    task automatic run_row(input row_t row);
        int   cycles;
        int   completed;
        logic done_seen;
        logic ext_seen;
        completed = completed_words(row);
        // Reads start from a cleared buffer and writes from fresh random words
        for (int i = 0; i < int'(row.block_length); i++) begin
            image[i] = row.read_n_write ? 32'd0 : $random(seed);
        end
        load_image(int'(row.block_length));

        @(negedge clock);
        assert (!busy) else log_error("busy high before launch");
        command.read_n_write = row.read_n_write;
        command.start.word_index = 30'(row.start);
        command.start.byte_offset = 2'b00;
        command.burst_length = row.burst_length;
        command.block_length = row.block_length;
        launch = 1'b1;
        ext_request = (row.ext_hold != 8'd0);
        @(negedge clock);
        launch = 1'b0;
        cycles = 1;
        done_seen = 1'b0;
        ext_seen = 1'b0;
        while (!done_seen) begin
            if (cycles >= int'(row.ext_hold)) ext_request = 1'b0;
            if (ext_grant) ext_seen = 1'b1;
            assert (busy) else log_error("busy low before done");
            assert (!(status.done && ext_grant)) else log_error("done while ext_grant high");
            if (status.done) begin
                done_seen = 1'b1;
                assert (status.error == row.expect_error) else
                    log_error($sformatf("error flag %b, expected %b",
                                        status.error, row.expect_error));
            end else begin
                @(negedge clock);
                cycles++;
            end
        end

        @(negedge clock);
        ext_request = 1'b0;
        assert (!status.done) else log_error("done longer than one cycle");
        assert (!busy) else log_error("busy still high the cycle after done");
        assert (status.error == row.expect_error) else log_error("error flag not held");
        if (row.ext_hold != 8'd0) begin
            assert (ext_seen) else log_error("ext_grant never rose");
        end

        for (int i = 0; i < completed; i++) begin
            if (row.read_n_write) begin
                image[i] = model[int'(row.start) + i];
            end else begin
                model[int'(row.start) + i] = image[i];
            end
        end
        if (row.read_n_write) check_image(int'(row.block_length));
    endtask

    initial begin
        row_t limit_row;
        n_reset = 1'b0;
        launch = 1'b0;
        command = '0;
        ext_request = 1'b0;
        ext_master = '0;
        host_address = '0;
        host_write = 1'b0;
        host_write_data = '0;
        seed = 97942;
        error_count = 0;
        cycle_count = 0;
        for (int i = 0; i < memory_depth; i++) model[i] = '0;
        for (int i = 0; i < buffer_depth; i++) image[i] = '0;
        timeout_limit = 0;
        for (int r = 0; r < row_count; r++) begin
            limit_row = row_at(r);
            timeout_limit += cycles_per_row + cycles_per_word * int'(limit_row.block_length);
        end

        repeat (10) @(negedge clock);
        n_reset = 1'b1;
        assert (!busy) else log_error("busy high after reset");

        for (int r = 0; r < row_count; r++) begin
            run_row(row_at(r));
        end

        $display("Errors counted: %0d", error_count);
        if (error_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== dma_subsystem.f ====
source/dma_pkg.sv
source/dma_controller.sv
source/dma_buffer.sv
source/bus_arbiter.sv
source/bus_memory.sv
source/dma_subsystem.sv
tests/dma_subsystem_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the DMA subsystem testbench with Verilator
log=sim.log
rm -f "$log"
verilator --binary --timing --assert -Wno-fatal -f dma_subsystem.f \
    --top-module dma_subsystem_tb -o dma_subsystem_sim > "$log" 2>&1 \
    && ./obj_dir/dma_subsystem_sim >> "$log" 2>&1 \
    || echo "Verification failed" >> "$log"
cat "$log"
grep -q "Verification failed" "$log" && exit 1 || exit 0
